// File: src/veripacPkg.sv
package veripacPkg;

    // Host memory map
    localparam logic [7:0] ramLength          = 8'hCA;
    localparam logic [7:0] controlRegAddr     = ramLength;
    localparam logic [7:0] accumulatorAddr    = ramLength + 8'd2;
    localparam logic [7:0] programCounterAddr = ramLength + 8'd3;
    localparam logic [7:0] regsStart          = 8'hF0;
    localparam int         numRegs            = 16;

    // Sequencer states
    localparam logic [1:0] stateFetch1 = 2'b00;
    localparam logic [1:0] stateFetch2 = 2'b01;
    localparam logic [1:0] stateExec   = 2'b10;
    localparam logic [1:0] stateHalt   = 2'b11;

    // Single byte opcodes
    localparam logic [7:0] opNop  = 8'h00;
    localparam logic [7:0] opClr  = 8'h01;
    localparam logic [7:0] opDec  = 8'h02;
    localparam logic [7:0] opInc  = 8'h03;
    localparam logic [7:0] opLdva = 8'h0A;
    localparam logic [7:0] opHalt = 8'hFF;
    localparam logic [7:0] opBdc  = 8'h11;
    localparam logic [7:0] opGto  = 8'h12;
    localparam logic [7:0] opBrz  = 8'h13;
    localparam logic [7:0] opBnc  = 8'h15;
    localparam logic [7:0] opBc   = 8'h16;

    // Register groups, upper nibble of the opcode
    localparam logic [3:0] grpBne  = 4'h2;
    localparam logic [3:0] grpBeq  = 4'h3;
    localparam logic [3:0] grpBgt  = 4'h4;
    localparam logic [3:0] grpBlt  = 4'h5;
    localparam logic [3:0] grpLdvr = 4'h6;
    localparam logic [3:0] grpLdar = 4'h9;
    localparam logic [3:0] grpStor = 4'hA;
    localparam logic [3:0] grpSub  = 4'hD;
    localparam logic [3:0] grpAdd  = 4'hE;

    // Accumulator operations
    localparam logic [3:0] aluNone        = 4'd0;
    localparam logic [3:0] aluClr         = 4'd1;
    localparam logic [3:0] aluInc         = 4'd2;
    localparam logic [3:0] aluDec         = 4'd3;
    localparam logic [3:0] aluLoadOperand = 4'd4;
    localparam logic [3:0] aluLoadReg     = 4'd5;
    localparam logic [3:0] aluAdd         = 4'd6;
    localparam logic [3:0] aluSub         = 4'd7;

    // Branch conditions, ten codes so four bits wide
    localparam logic [3:0] brNone       = 4'd0;
    localparam logic [3:0] brAlways     = 4'd1;
    localparam logic [3:0] brAccNonZero = 4'd2;
    localparam logic [3:0] brAccZero    = 4'd3;
    localparam logic [3:0] brCarry      = 4'd4;
    localparam logic [3:0] brNoCarry    = 4'd5;
    localparam logic [3:0] brAccNeReg   = 4'd6;
    localparam logic [3:0] brAccEqReg   = 4'd7;
    localparam logic [3:0] brRegGtAcc   = 4'd8;
    localparam logic [3:0] brRegLtAcc   = 4'd9;

    // One instruction byte, as a full opcode or as group plus register
    typedef union packed {
        logic [7:0] opcode;
        struct packed {
            logic [3:0] group;
            logic [3:0] index;
        } field;
    } instrWord_u;

endpackage

// File: src/veripacDecode.sv
module veripacDecode (
    input  logic [7:0] instrByte,
    output logic       twoByte,
    output logic [3:0] regIndex,
    output logic [3:0] aluOp,
    output logic [3:0] branchCond,
    output logic       writesReg,
    output logic       writeBackFromOperand,
    output logic       isHalt
);
    import veripacPkg::*;

    instrWord_u word;

    assign word     = instrByte;
    assign regIndex = word.field.index;
    assign isHalt   = word.opcode == opHalt;

    // Byte branches and LDVA carry an operand, as do the register groups 2 to 6
    assign twoByte = (word.opcode == opLdva)
                  || (word.opcode >= opBdc && word.opcode <= opBc)
                  || (word.field.group >= grpBne && word.field.group <= grpLdvr);

    always_comb begin
        aluOp                = aluNone;
        branchCond           = brNone;
        writesReg            = 1'b0;
        writeBackFromOperand = 1'b0;
        case (word.opcode)
            opNop:  aluOp = aluNone;
            opClr:  aluOp = aluClr;
            opDec:  aluOp = aluDec;
            opInc:  aluOp = aluInc;
            opLdva: aluOp = aluLoadOperand;
            opBdc:  branchCond = brAccNonZero;
            opGto:  branchCond = brAlways;
            opBrz:  branchCond = brAccZero;
            opBnc:  branchCond = brNoCarry;
            opBc:   branchCond = brCarry;
            default: begin
                case (word.field.group)
                    grpBne:  branchCond = brAccNeReg;
                    grpBeq:  branchCond = brAccEqReg;
                    grpBgt:  branchCond = brRegGtAcc;
                    grpBlt:  branchCond = brRegLtAcc;
                    grpLdvr: begin
                        writesReg            = 1'b1;
                        writeBackFromOperand = 1'b1;
                    end
                    grpLdar: aluOp = aluLoadReg;
                    grpStor: writesReg = 1'b1;
                    grpSub:  aluOp = aluSub;
                    grpAdd:  aluOp = aluAdd;
                    // Unknown opcodes fall through as NOP
                    default: aluOp = aluNone;
                endcase
            end
        endcase
    end

endmodule

// File: src/veripacExecute.sv
module veripacExecute (
    input  logic       clk,
    input  logic       reset,
    input  logic       execStrobe,
    input  logic [3:0] aluOp,
    input  logic [3:0] branchCond,
    input  logic [7:0] regValue,
    input  logic [7:0] operand,
    input  logic       accWrite,
    input  logic [7:0] hostData,
    output logic [7:0] accumulator,
    output logic       carry,
    output logic       branchTaken
);
    import veripacPkg::*;

    // Carry in bit 8, holds the borrow for subtraction
    logic [8:0] aluResult;

    always_comb begin
        case (aluOp)
            aluNone:        aluResult = {carry, accumulator};
            aluClr:         aluResult = {carry, 8'h00};
            aluInc:         aluResult = {1'b0, accumulator} + 9'd1;
            aluDec:         aluResult = {1'b0, accumulator} - 9'd1;
            aluLoadOperand: aluResult = {carry, operand};
            aluLoadReg:     aluResult = {carry, regValue};
            aluAdd:         aluResult = {1'b0, regValue} + {1'b0, accumulator};
            // Register minus accumulator
            aluSub:         aluResult = {1'b0, regValue} - {1'b0, accumulator};
            default:        aluResult = {carry, accumulator};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            accumulator <= 8'h00;
            carry       <= 1'b0;
        end else if (accWrite) begin
            accumulator <= hostData;
        end else if (execStrobe) begin
            accumulator <= aluResult[7:0];
            carry       <= aluResult[8];
        end
    end

    // Evaluated on the values in place before the execute edge
    always_comb begin
        case (branchCond)
            brNone:       branchTaken = 1'b0;
            brAlways:     branchTaken = 1'b1;
            brAccNonZero: branchTaken = accumulator != 8'h00;
            brAccZero:    branchTaken = accumulator == 8'h00;
            brCarry:      branchTaken = carry;
            brNoCarry:    branchTaken = !carry;
            brAccNeReg:   branchTaken = accumulator != regValue;
            brAccEqReg:   branchTaken = accumulator == regValue;
            brRegGtAcc:   branchTaken = regValue > accumulator;
            brRegLtAcc:   branchTaken = regValue < accumulator;
            default:      branchTaken = 1'b0;
        endcase
    end

endmodule

// File: src/veripacRegisterFile.sv
module veripacRegisterFile (
    input  logic       clk,
    input  logic       execStrobe,
    input  logic       writesReg,
    input  logic [3:0] regIndex,
    input  logic [7:0] writeBackData,
    input  logic       regWrite,
    input  logic [3:0] hostRegIndex,
    input  logic [7:0] hostData,
    output logic [7:0] regValue,
    input  logic [3:0] hostReadIndex,
    output logic [7:0] hostReadValue
);
    import veripacPkg::*;

    logic [7:0] regs [numRegs];

    // Host write wins over write-back
    always_ff @(posedge clk) begin
        if (regWrite) begin
            regs[hostRegIndex] <= hostData;
        end else if (execStrobe && writesReg) begin
            regs[regIndex] <= writeBackData;
        end
    end

    // Operand register for execute
    assign regValue = regs[regIndex];

    assign hostReadValue = regs[hostReadIndex];

endmodule

// File: src/veripacSequencer.sv
module veripacSequencer (
    input  logic       clk,
    input  logic       reset,
    input  logic       step,
    input  logic       rd,
    input  logic       wr,
    input  logic       ramWrite,
    input  logic       pcWrite,
    input  logic [7:0] addr,
    input  logic [7:0] hostData,
    input  logic       twoByte,
    input  logic       isHalt,
    input  logic       branchTaken,
    output logic [7:0] instrByte,
    output logic [7:0] operand,
    output logic       execStrobe,
    output logic [1:0] state,
    output logic [7:0] programCounter,
    output logic [7:0] ramReadValue
);
    import veripacPkg::*;

    logic [7:0] ram [0:ramLength-1];
    logic       prevStep;
    logic       hostIdle;
    logic       stepEdge;
    logic       pcInRam;

    assign hostIdle   = !rd && !wr;
    assign stepEdge   = step && !prevStep && hostIdle;
    assign execStrobe = stepEdge && (state == stateExec);
    assign pcInRam    = programCounter < ramLength;

    always_ff @(posedge clk) begin
        if (ramWrite) begin
            ram[addr] <= hostData;
        end
    end

    assign ramReadValue = (addr < ramLength) ? ram[addr] : 8'h00;

    // Held while the host is on the bus so its access cannot make an edge
    always_ff @(posedge clk) begin
        if (hostIdle) begin
            prevStep <= step;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= stateFetch1;
            programCounter <= 8'h00;
        end else if (pcWrite) begin
            programCounter <= hostData;
        end else if (stepEdge) begin
            case (state)
                stateFetch1: begin
                    if (!pcInRam) begin
                        state <= stateHalt;
                    end else begin
                        instrByte      <= ram[programCounter];
                        programCounter <= programCounter + 8'd1;
                        state          <= stateFetch2;
                    end
                end
                stateFetch2: begin
                    if (!twoByte) begin
                        operand <= 8'h00;
                        state   <= stateExec;
                    end else if (!pcInRam) begin
                        state <= stateHalt;
                    end else begin
                        operand        <= ram[programCounter];
                        programCounter <= programCounter + 8'd1;
                        state          <= stateExec;
                    end
                end
                stateExec: begin
                    if (branchTaken) begin
                        programCounter <= operand;
                    end
                    state <= isHalt ? stateHalt : stateFetch1;
                end
                // Only reset leaves HALT
                default: state <= stateHalt;
            endcase
        end
    end

endmodule

// File: src/veripacHostBus.sv
module veripacHostBus (
    input  logic       rd,
    input  logic       wr,
    input  logic [7:0] addr,
    input  logic [7:0] ramReadValue,
    input  logic [7:0] hostReadValue,
    input  logic [7:0] accumulator,
    input  logic [7:0] programCounter,
    input  logic [1:0] state,
    output logic       ramWrite,
    output logic       regWrite,
    output logic [3:0] hostRegIndex,
    output logic       accWrite,
    output logic       pcWrite,
    output logic [7:0] dout
);
    import veripacPkg::*;

    logic inRam;
    logic inRegs;

    assign inRam  = addr < ramLength;
    assign inRegs = addr >= regsStart;

    assign ramWrite = wr && inRam;
    assign regWrite = wr && inRegs;
    assign accWrite = wr && (addr == accumulatorAddr);
    assign pcWrite  = wr && (addr == programCounterAddr);

    // Register window sits on a 16 byte boundary
    assign hostRegIndex = addr[3:0];

    always_comb begin
        dout = 8'h00;
        if (rd) begin
            if (inRam) begin
                dout = ramReadValue;
            end else if (inRegs) begin
                dout = hostReadValue;
            end else begin
                case (addr)
                    controlRegAddr:     dout = {6'b000000, state};
                    accumulatorAddr:    dout = accumulator;
                    programCounterAddr: dout = programCounter;
                    default:            dout = 8'h00;
                endcase
            end
        end
    end

endmodule

// File: src/veripac9.sv
module veripac9 (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] addr,
    input  logic       rd,
    input  logic       wr,
    input  logic [7:0] din,
    output logic [7:0] dout,
    input  logic       step
);

    logic       ramWrite;
    logic       regWrite;
    logic       accWrite;
    logic       pcWrite;
    logic [3:0] hostRegIndex;
    logic [7:0] ramReadValue;
    logic [7:0] hostReadValue;
    logic [7:0] accumulator;
    logic [7:0] programCounter;
    logic [1:0] state;
    logic [7:0] instrByte;
    logic [7:0] operand;
    logic       execStrobe;
    logic       twoByte;
    logic [3:0] regIndex;
    logic [3:0] aluOp;
    logic [3:0] branchCond;
    logic       writesReg;
    logic       writeBackFromOperand;
    logic       isHalt;
    logic [7:0] regValue;
    logic       carry;
    logic       branchTaken;
    logic [7:0] writeBackData;

    // STOR writes the accumulator, LDVR the operand
    assign writeBackData = writeBackFromOperand ? operand : accumulator;

    veripacHostBus hostBus_i (
        .rd, .wr, .addr, .ramReadValue, .hostReadValue, .accumulator,
        .programCounter, .state, .ramWrite, .regWrite, .hostRegIndex,
        .accWrite, .pcWrite, .dout
    );

    veripacSequencer sequencer_i (
        .clk, .reset, .step, .rd, .wr, .ramWrite, .pcWrite, .addr,
        .hostData(din), .twoByte, .isHalt, .branchTaken, .instrByte,
        .operand, .execStrobe, .state, .programCounter, .ramReadValue
    );

    veripacDecode decode_i (
        .instrByte, .twoByte, .regIndex, .aluOp, .branchCond,
        .writesReg, .writeBackFromOperand, .isHalt
    );

    veripacExecute execute_i (
        .clk, .reset, .execStrobe, .aluOp, .branchCond, .regValue, .operand,
        .accWrite, .hostData(din), .accumulator, .carry, .branchTaken
    );

    veripacRegisterFile registerFile_i (
        .clk, .execStrobe, .writesReg, .regIndex, .writeBackData, .regWrite,
        .hostRegIndex, .hostData(din), .regValue,
        .hostReadIndex(hostRegIndex), .hostReadValue
    );

endmodule

// File: sim/veripacClock.sv
module veripacClock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held over the first three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: sim/veripac_props.sv
module veripacProps (
    input logic       clk,
    input logic       reset,
    input logic       stepEdge,
    input logic       execStrobe,
    input logic [1:0] state
);
    timeunit 1ns;
    timeprecision 1ps;

    import veripacPkg::*;

    stateOnlyOnStep: assert property (
        @(posedge clk) (!reset && !stepEdge) |=> $stable(state)
    ) else $error("sequencer state changed without a step edge or reset");

    cleanAfterReset: assert property (
        @(posedge clk) reset |=> (state == stateFetch1) && !execStrobe
    ) else $error("sequencer not in FETCH1 with execStrobe low after reset");

    haltIsSticky: assert property (
        @(posedge clk) (state == stateHalt) && !reset |=> state == stateHalt
    ) else $error("sequencer left HALT without reset");

endmodule

bind veripacSequencer veripacProps props_i (
    .clk,
    .reset,
    .stepEdge,
    .execStrobe,
    .state
);

// File: sim/veripacTb.sv
module veripacTb;
    timeunit 1ns;
    timeprecision 1ps;

    import veripacPkg::*;

    typedef struct packed {
        logic [7:0]       acc;
        logic             carry;
        logic [7:0]       pc;
        logic [15:0][7:0] regs;
        logic             halted;
    } modelState_t;

    logic       clk;
    logic       clkReset;
    logic       forceReset;
    logic       reset;
    logic [7:0] addr;
    logic       rd;
    logic       wr;
    logic [7:0] din;
    logic [7:0] dout;
    logic       step;

    logic [7:0]  ramImage [256];
    modelState_t model;
    int          mismatches;
    int          otherErrors;
    event        compareReq;
    bit          compareBusy;
    string       compareName;

    veripacClock clock_i (.clk(clk), .reset(clkReset));

    assign reset = clkReset || forceReset;

    veripac9 dut_i (
        .clk, .reset, .addr, .rd, .wr, .din, .dout, .step
    );

    // Next model state after one whole instruction
    function automatic modelState_t refExecute(input modelState_t s,
                                               input logic [7:0] mem [256]);
        modelState_t n;
        instrWord_u  w;
        logic [7:0]  opnd;
        logic [7:0]  r;
        logic [8:0]  sum;
        logic        twoB;
        logic        taken;
        n = s;
        if (s.halted) return n;
        if (n.pc >= ramLength) begin
            n.halted = 1'b1;
            return n;
        end
        w = mem[n.pc];
        n.pc = n.pc + 8'd1;
        twoB = (w.opcode == opLdva) || (w.opcode >= 8'h11 && w.opcode <= 8'h16)
            || (w.field.group >= 4'h2 && w.field.group <= 4'h6);
        opnd = 8'h00;
        if (twoB) begin
            if (n.pc >= ramLength) begin
                n.halted = 1'b1;
                return n;
            end
            opnd = mem[n.pc];
            n.pc = n.pc + 8'd1;
        end
        r = s.regs[w.field.index];
        taken = 1'b0;
        case (w.opcode)
            opClr:  n.acc = 8'h00;
            opDec:  begin
                sum = {1'b0, s.acc} - 9'd1;
                {n.carry, n.acc} = sum;
            end
            opInc:  begin
                sum = {1'b0, s.acc} + 9'd1;
                {n.carry, n.acc} = sum;
            end
            opLdva: n.acc = opnd;
            opHalt: n.halted = 1'b1;
            opBdc:  taken = s.acc != 8'h00;
            opGto:  taken = 1'b1;
            opBrz:  taken = s.acc == 8'h00;
            opBnc:  taken = !s.carry;
            opBc:   taken = s.carry;
            default: begin
                case (w.field.group)
                    grpBne:  taken = s.acc != r;
                    grpBeq:  taken = s.acc == r;
                    grpBgt:  taken = r > s.acc;
                    grpBlt:  taken = r < s.acc;
                    grpLdvr: n.regs[w.field.index] = opnd;
                    grpLdar: n.acc = r;
                    grpStor: n.regs[w.field.index] = s.acc;
                    grpSub:  {n.carry, n.acc} = {1'b0, r} - {1'b0, s.acc};
                    grpAdd:  {n.carry, n.acc} = {1'b0, r} + {1'b0, s.acc};
                    default: ;
                endcase
            end
        endcase
        if (taken) n.pc = opnd;
        return n;
    endfunction

    task automatic checkEq(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
        assert (expected === actual) else begin
            $display("MISMATCH %s: expected %02h actual %02h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic timeoutFail(input string what);
        otherErrors++;
        $display("Timeout: %s", what);
        $display("Errors: %0d mismatches, %0d other", mismatches, otherErrors);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic hostWrite(input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        addr = a;
        din  = d;
        wr   = 1'b1;
        @(posedge clk);
        #1 wr = 1'b0;
    endtask

    task automatic hostRead(input logic [7:0] a, output logic [7:0] d);
        @(posedge clk);
        #1;
        addr = a;
        rd   = 1'b1;
        #2 d = dout;
        @(posedge clk);
        #1 rd = 1'b0;
    endtask

    // Host write that keeps the model in step
    task automatic loadByte(input logic [7:0] a, input logic [7:0] d);
        hostWrite(a, d);
        if (a < ramLength) ramImage[a] = d;
        else if (a >= regsStart) model.regs[a[3:0]] = d;
        else if (a == accumulatorAddr) model.acc = d;
        else if (a == programCounterAddr) model.pc = d;
    endtask

    task automatic pulseStep();
        @(posedge clk);
        #1 step = 1'b1;
        @(posedge clk);
        #1 step = 1'b0;
        @(posedge clk);
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1 forceReset = 1'b1;
        repeat (2) @(posedge clk);
        #1 forceReset = 1'b0;
        model.acc    = 8'h00;
        model.carry  = 1'b0;
        model.pc     = 8'h00;
        model.halted = 1'b0;
    endtask

    task automatic compareState(input string name);
        int n;
        n = 0;
        compareName = name;
        compareBusy = 1'b1;
        -> compareReq;
        while (compareBusy) begin
            @(posedge clk);
            n++;
            if (n > 200) timeoutFail("compare process did not finish");
        end
    endtask

    task automatic runInstr(input string name, input logic [7:0] b0, input logic [7:0] b1);
        loadByte(8'h20, b0);
        loadByte(8'h21, b1);
        loadByte(programCounterAddr, 8'h20);
        repeat (3) pulseStep();
        model = refExecute(model, ramImage);
        compareState(name);
    endtask

    // Reads the whole visible state back and compares with the model
    initial begin
        logic [7:0] got;
        forever begin
            @compareReq;
            hostRead(accumulatorAddr, got);
            checkEq($sformatf("%s acc", compareName), model.acc, got);
            hostRead(programCounterAddr, got);
            checkEq($sformatf("%s pc", compareName), model.pc, got);
            hostRead(controlRegAddr, got);
            checkEq($sformatf("%s control", compareName),
                    {6'b0, model.halted ? stateHalt : stateFetch1}, got);
            for (int i = 0; i < numRegs; i++) begin
                hostRead(regsStart + 8'(i), got);
                checkEq($sformatf("%s r%0d", compareName, i), model.regs[i], got);
            end
            compareBusy = 1'b0;
        end
    end

    initial begin
        logic [7:0] a;
        logic [7:0] d;
        logic [7:0] got;
        logic [7:0] op;
        logic [7:0] accVal;
        logic [3:0] r;
        logic       accOp;
        logic       carryOp;
        int         n;
        logic [7:0] branchOps [9];

        addr = 8'h00;
        rd = 1'b0;
        wr = 1'b0;
        din = 8'h00;
        step = 1'b0;
        forceReset = 1'b0;
        mismatches = 0;
        otherErrors = 0;
        compareBusy = 1'b0;
        model = '0;
        for (int i = 0; i < 256; i++) ramImage[i] = 8'h00;
        void'($urandom(32'hc1fb_b335));

        n = 0;
        while (reset !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > 20) timeoutFail("reset never released");
        end

        // Host round trip
        for (int i = 0; i < 24; i++) begin
            a = 8'($urandom % ramLength);
            d = 8'($urandom);
            loadByte(a, d);
            hostRead(a, got);
            checkEq($sformatf("ram %02h", a), d, got);
        end
        for (int i = 0; i < numRegs; i++) begin
            d = 8'($urandom);
            loadByte(regsStart + 8'(i), d);
        end
        loadByte(accumulatorAddr, 8'($urandom));
        loadByte(programCounterAddr, 8'($urandom));
        compareState("host");

        // Random arithmetic and carry branches
        for (int i = 0; i < 48; i++) begin
            r = 4'($urandom);
            d = 8'($urandom);
            case ($urandom % 11)
                0:  op = opLdva;
                1:  op = {grpLdvr, r};
                2:  op = {grpLdar, r};
                3:  op = {grpAdd, r};
                4:  op = {grpSub, r};
                5:  op = opInc;
                6:  op = opDec;
                7:  op = opClr;
                8:  op = {grpStor, r};
                9:  op = opNop;
                default: op = ($urandom % 2) ? opBc : opBnc;
            endcase
            runInstr($sformatf("arith %0d op %02h", i, op), op, d);
        end

        // Branches taken and not taken
        branchOps = '{opBdc, opGto, opBrz, opBnc, opBc,
                      {grpBne, 4'h5}, {grpBeq, 4'h5}, {grpBgt, 4'h5}, {grpBlt, 4'h5}};
        foreach (branchOps[b]) begin
            op = branchOps[b];
            carryOp = (op == opBc) || (op == opBnc);
            accOp = carryOp || (op == opBdc) || (op == opBrz);
            for (int k = 0; k < 3; k++) begin
                d = 8'(1 + $urandom % 254);
                accVal = (k == 0 && accOp) ? (carryOp ? 8'hFF : 8'h00) : d;
                loadByte(accumulatorAddr, accVal);
                loadByte(regsStart + 8'h5, (k == 0) ? d : (k == 1) ? d + 8'd1 : d - 8'd1);
                if (carryOp) runInstr("carry setup", opInc, 8'h00);
                runInstr($sformatf("branch %02h case %0d", op, k), op, 8'h40 + 8'(k));
            end
        end

        // HALT holds until reset
        runInstr("halt", opHalt, 8'h00);
        repeat (3) pulseStep();
        compareState("halt hold");
        applyReset();
        compareState("halt reset");

        // Running off the end of RAM
        for (int i = 4; i > 0; i--) loadByte(ramLength - 8'(i), opNop);
        loadByte(programCounterAddr, ramLength - 8'd4);
        n = 0;
        got = 8'h00;
        while (got != {6'b0, stateHalt}) begin
            pulseStep();
            hostRead(controlRegAddr, got);
            n++;
            if (n > 40) timeoutFail("no HALT after running off RAM");
        end
        while (!model.halted) model = refExecute(model, ramImage);
        compareState("off ram");

        // Reset in the middle of an instruction
        applyReset();
        loadByte(accumulatorAddr, 8'hA5);
        loadByte(8'h20, opLdva);
        loadByte(8'h21, 8'h5A);
        loadByte(programCounterAddr, 8'h20);
        pulseStep();
        applyReset();
        compareState("mid reset");

        $display("Errors: %0d mismatches, %0d other", mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: veripac9.f
src/veripacPkg.sv
src/veripacDecode.sv
src/veripacExecute.sv
src/veripacRegisterFile.sv
src/veripacSequencer.sv
src/veripacHostBus.sv
src/veripac9.sv
sim/veripacClock.sv
sim/veripac_props.sv
sim/veripacTb.sv

// File: run.sh
#!/bin/sh
# Build and run the veripac9 testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f veripac9.f --top-module veripacTb \
    --Mdir obj_dir -o veripacSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/veripacSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST OK" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
